/* hdl/a2_glue_consts.svh */
// Build constants for the card glue logic
// Audio placement shifts, LED bit positions, default blink period
// and the switches that allow driving the Apple II bus
`ifndef A2_GLUE_CONSTS_SVH
`define A2_GLUE_CONSTS_SVH

// Audio placement inside the 16-bit sample
`define A2G_CARD_AUDIO_SHIFT 3          // 10-bit card level into 13 bits
`define A2G_SPEAKER_SHIFT    12         // Speaker bit sits at the top of 13 bits

// LED bit selection
`define A2G_ACTIVITY_BIT     8          // Event counter bit shown during activity
`define A2G_CLOCK_LED_BIT    10         // MSB of the 11-bit clock edge counters

// Heartbeat period in clk_logic_w cycles
`define A2G_BLINK_CYCLES     10_000_000

// Bus drive switches, 0 keeps the pin released
`define A2G_IRQ_OUT_ENABLE   1
`define A2G_DATA_OUT_ENABLE  1

`endif

/* hdl/a2_glue_pkg.sv */
// Shared types of the card glue logic
// Bus byte, card audio level, signed sample and event counter
`default_nettype none

package a2_glue_pkg;

    // One byte on the Apple II data bus
    typedef logic [7:0] bus_byte_t;

    // Unsigned audio level from a slot card
    typedef logic [9:0] card_audio_t;

    // Signed 16-bit audio sample, one channel
    typedef logic signed [15:0] sample_t;

    // Sound-chip event counter
    typedef logic [15:0] event_count_t;

endpackage

`default_nettype wire

/* hdl/card_resp_if.sv */
// Card response bundle
// Read data, read enables and interrupt requests of the serial,
// sprite and sound cards, with a driver and an arbiter view
`default_nettype none

interface card_resp_if;
    import a2_glue_pkg::*;

    // Serial card
    bus_byte_t ssc_data;
    logic      ssc_rd;      // High while the card answers a read
    logic      ssc_irq_n;   // Low while an interrupt is requested

    // Sprite card
    bus_byte_t ssp_data;
    logic      ssp_rd;
    logic      ssp_irq_n;

    // Sound card
    bus_byte_t mb_data;
    logic      mb_rd;
    logic      mb_irq_n;

    // Driven by the card side
    modport cards (
        output ssc_data, ssc_rd, ssc_irq_n,
        output ssp_data, ssp_rd, ssp_irq_n,
        output mb_data,  mb_rd,  mb_irq_n
    );

    // Read by the bus arbiter
    modport arbiter (
        input ssc_data, ssc_rd, ssc_irq_n,
        input ssp_data, ssp_rd, ssp_irq_n,
        input mb_data,  mb_rd,  mb_irq_n
    );

endinterface

`default_nettype wire

/* hdl/card_bus_arbiter.sv */
// Card bus arbiter
// Fixed priority data mux onto the Apple II bus, data direction
// control and open-drain IRQ combination
`default_nettype none

`include "a2_glue_consts.svh"

module card_bus_arbiter (
    card_resp_if.arbiter            cards_if,
    input  a2_glue_pkg::bus_byte_t  a2_data_i,
    output a2_glue_pkg::bus_byte_t  data_out_o,
    output logic                    d_dir_o,
    output logic                    irq_n_o     // Open drain, never driven high
);
    logic any_rd_w;
    logic irq_req_w;

    assign any_rd_w  = cards_if.ssc_rd | cards_if.ssp_rd | cards_if.mb_rd;
    assign irq_req_w = ~(cards_if.ssc_irq_n & cards_if.ssp_irq_n & cards_if.mb_irq_n);

    // Serial card wins, then sprite, then sound card
    always_comb begin
        if (cards_if.ssc_rd) begin
            data_out_o = cards_if.ssc_data;
        end else if (cards_if.ssp_rd) begin
            data_out_o = cards_if.ssp_data;
        end else if (cards_if.mb_rd) begin
            data_out_o = cards_if.mb_data;
        end else begin
            data_out_o = a2_data_i;     // Nobody answers, echo the bus
        end
    end

    // Transceiver points toward the Apple II only while a card reads
    assign d_dir_o = any_rd_w && (`A2G_DATA_OUT_ENABLE != 0);

    // Pull IRQ low on any request, otherwise release the line
    assign irq_n_o = (irq_req_w && (`A2G_IRQ_OUT_ENABLE != 0)) ? 1'b0 : 1'bz;

endmodule

`default_nettype wire

/* hdl/audio_mixer.sv */
// Audio mixer
// Places the speaker bit and the unsigned card levels in a 16-bit word,
// adds the optional external signed sample and registers both channels
`default_nettype none

`include "a2_glue_consts.svh"

module audio_mixer #(
    parameter bit ESP32_AUDIO_EN = 1'b1     // 1 adds the external stereo sample
) (
    input  logic                      clk_logic_w,
    input  logic                      system_reset_n_w,
    input  logic                      speaker_i,
    input  a2_glue_pkg::card_audio_t  ssp_audio_i,
    input  a2_glue_pkg::card_audio_t  mb_audio_l_i,
    input  a2_glue_pkg::card_audio_t  mb_audio_r_i,
    input  a2_glue_pkg::sample_t      ext_l_i,
    input  a2_glue_pkg::sample_t      ext_r_i,
    output a2_glue_pkg::sample_t      audio_l_o,
    output a2_glue_pkg::sample_t      audio_r_o
);
    import a2_glue_pkg::*;

    localparam int SW = $bits(sample_t);

    sample_t mix_l_w;
    sample_t mix_r_w;

    // One channel: unsigned sources at their positions plus the external sample,
    // sum wraps at 16 bits
    function automatic sample_t mix_channel(
        input logic        spk,
        input card_audio_t ssp,
        input card_audio_t mb,
        input sample_t     ext
    );
        logic [SW-1:0] spk_ext;
        logic [SW-1:0] ssp_ext;
        logic [SW-1:0] mb_ext;
        logic [SW-1:0] ext_add;
        spk_ext = SW'(spk) << `A2G_SPEAKER_SHIFT;
        ssp_ext = SW'(ssp) << `A2G_CARD_AUDIO_SHIFT;
        mb_ext  = SW'(mb) << `A2G_CARD_AUDIO_SHIFT;
        ext_add = ESP32_AUDIO_EN ? SW'(unsigned'(ext)) : '0;
        return sample_t'(spk_ext + ssp_ext + mb_ext + ext_add);
    endfunction

    assign mix_l_w = mix_channel(speaker_i, ssp_audio_i, mb_audio_l_i, ext_l_i);
    assign mix_r_w = mix_channel(speaker_i, ssp_audio_i, mb_audio_r_i, ext_r_i);

    // Output samples are silent out of reset
    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            audio_l_o <= '0;
            audio_r_o <= '0;
        end else begin
            audio_l_o <= mix_l_w;
            audio_r_o <= mix_r_w;
        end
    end

endmodule

`default_nettype wire

/* hdl/status_led.sv */
// Status LEDs
// Two-flop synchronizers and rising edge dividers for the phi1 and Q3
// bus clocks, plus the heartbeat LED with sound-chip activity display
`default_nettype none

`include "a2_glue_consts.svh"

module status_led #(
    parameter int BLINK_CYCLES = `A2G_BLINK_CYCLES     // Any value of 2 or more
) (
    input  logic                       clk_logic_w,
    input  logic                       system_reset_n_w,
    input  logic                       phi1_i,
    input  logic                       q3_i,
    input  a2_glue_pkg::event_count_t  es5503_count_i,
    output logic                       heartbeat_led_o,
    output logic                       phi1_led_o,
    output logic                       q3_led_o
);
    import a2_glue_pkg::*;

    localparam int NCLK    = 2;                         // phi1 at index 0, Q3 at 1
    localparam int EDGE_W  = `A2G_CLOCK_LED_BIT + 1;
    localparam int BLINK_W = $clog2(BLINK_CYCLES);

    logic [NCLK-1:0]   clk_in_w;
    logic [2:0]        sync_r [NCLK];                   // Two sync stages and last value
    logic [NCLK-1:0]   rise_w;
    logic [EDGE_W-1:0] edge_cnt_r [NCLK];

    logic [BLINK_W-1:0] blink_cnt_r;
    logic               blink_wrap_w;
    event_count_t       prev_count_r;
    logic               count_changed_w;
    logic               activity_r;

    assign clk_in_w = {q3_i, phi1_i};

    // Rising edge seen on the synchronized copy
    always_comb begin
        for (int i = 0; i < NCLK; i++) begin
            rise_w[i] = sync_r[i][1] & ~sync_r[i][2];
        end
    end

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            for (int i = 0; i < NCLK; i++) begin
                sync_r[i]     <= '0;
                edge_cnt_r[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NCLK; i++) begin
                sync_r[i] <= {sync_r[i][1:0], clk_in_w[i]};
                if (rise_w[i]) begin
                    edge_cnt_r[i] <= edge_cnt_r[i] + EDGE_W'(1);
                end
            end
        end
    end

    assign phi1_led_o = edge_cnt_r[0][`A2G_CLOCK_LED_BIT];
    assign q3_led_o   = edge_cnt_r[1][`A2G_CLOCK_LED_BIT];

    // Previous event count for change detection
    always_ff @(posedge clk_logic_w) begin
        prev_count_r <= es5503_count_i;
    end

    assign count_changed_w = (es5503_count_i != prev_count_r);
    assign blink_wrap_w    = (blink_cnt_r == BLINK_W'(BLINK_CYCLES - 1));

    always_ff @(posedge clk_logic_w) begin
        if (!system_reset_n_w) begin
            blink_cnt_r     <= '0;
            activity_r      <= 1'b0;
            heartbeat_led_o <= 1'b0;
        end else begin
            if (count_changed_w) begin
                activity_r <= 1'b1;
            end
            if (blink_wrap_w) begin
                blink_cnt_r <= '0;
                if (activity_r) begin
                    heartbeat_led_o <= es5503_count_i[`A2G_ACTIVITY_BIT];  // Sound chip busy
                    activity_r      <= 1'b0;    // Clear wins over a same-cycle change
                end else begin
                    heartbeat_led_o <= ~heartbeat_led_o;                    // Idle heartbeat
                end
            end else begin
                blink_cnt_r <= blink_cnt_r + BLINK_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/a2_card_glue_top.sv */
// Card glue top level
// Plain chip ports, the card response bundle, bus arbiter,
// audio mixer and status LEDs
`default_nettype none

`include "a2_glue_consts.svh"

module a2_card_glue_top #(
    parameter int BLINK_CYCLES   = `A2G_BLINK_CYCLES,
    parameter bit ESP32_AUDIO_EN = 1'b1
) (
    input  logic                       clk_logic_w,
    input  logic                       system_reset_n_w,

    // Serial card
    input  a2_glue_pkg::bus_byte_t     ssc_data_i,
    input  logic                       ssc_rd_i,
    input  logic                       ssc_irq_n_i,

    // Sprite card
    input  a2_glue_pkg::bus_byte_t     ssp_data_i,
    input  logic                       ssp_rd_i,
    input  logic                       ssp_irq_n_i,

    // Sound card
    input  a2_glue_pkg::bus_byte_t     mb_data_i,
    input  logic                       mb_rd_i,
    input  logic                       mb_irq_n_i,

    // Apple II bus
    input  a2_glue_pkg::bus_byte_t     a2_data_i,
    input  logic                       phi1_i,          // Asynchronous bus clocks
    input  logic                       q3_i,
    output a2_glue_pkg::bus_byte_t     data_out_o,
    output logic                       d_dir_o,
    output logic                       irq_n_o,

    // Audio sources
    input  logic                       speaker_i,
    input  a2_glue_pkg::card_audio_t   ssp_audio_i,
    input  a2_glue_pkg::card_audio_t   mb_audio_l_i,
    input  a2_glue_pkg::card_audio_t   mb_audio_r_i,
    input  a2_glue_pkg::sample_t       ext_l_i,         // External stereo sample
    input  a2_glue_pkg::sample_t       ext_r_i,
    output a2_glue_pkg::sample_t       audio_l_o,
    output a2_glue_pkg::sample_t       audio_r_o,

    // Status
    input  a2_glue_pkg::event_count_t  es5503_count_i,
    output logic                       heartbeat_led_o,
    output logic                       phi1_led_o,
    output logic                       q3_led_o
);

    card_resp_if cards_if ();

    // Card side of the bundle
    assign cards_if.ssc_data  = ssc_data_i;
    assign cards_if.ssc_rd    = ssc_rd_i;
    assign cards_if.ssc_irq_n = ssc_irq_n_i;
    assign cards_if.ssp_data  = ssp_data_i;
    assign cards_if.ssp_rd    = ssp_rd_i;
    assign cards_if.ssp_irq_n = ssp_irq_n_i;
    assign cards_if.mb_data   = mb_data_i;
    assign cards_if.mb_rd     = mb_rd_i;
    assign cards_if.mb_irq_n  = mb_irq_n_i;

    card_bus_arbiter card_bus_arbiter (
        .cards_if   (cards_if),
        .a2_data_i  (a2_data_i),
        .data_out_o (data_out_o),
        .d_dir_o    (d_dir_o),
        .irq_n_o    (irq_n_o)
    );

    audio_mixer #(
        .ESP32_AUDIO_EN (ESP32_AUDIO_EN)
    ) audio_mixer (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .speaker_i        (speaker_i),
        .ssp_audio_i      (ssp_audio_i),
        .mb_audio_l_i     (mb_audio_l_i),
        .mb_audio_r_i     (mb_audio_r_i),
        .ext_l_i          (ext_l_i),
        .ext_r_i          (ext_r_i),
        .audio_l_o        (audio_l_o),
        .audio_r_o        (audio_r_o)
    );

    // Heartbeat plus bus clock presence
    status_led #(
        .BLINK_CYCLES (BLINK_CYCLES)
    ) status_led (
        .clk_logic_w      (clk_logic_w),
        .system_reset_n_w (system_reset_n_w),
        .phi1_i           (phi1_i),
        .q3_i             (q3_i),
        .es5503_count_i   (es5503_count_i),
        .heartbeat_led_o  (heartbeat_led_o),
        .phi1_led_o       (phi1_led_o),
        .q3_led_o         (q3_led_o)
    );

endmodule

`default_nettype wire

/* sim/a2_card_glue_asserts.sv */
// Concurrent checks bound into the card glue top level
// Bus direction and open-drain IRQ rules, audio state out of reset
`default_nettype none

module a2_card_glue_asserts (
    input  logic                  clk_logic_w,
    input  logic                  system_reset_n_w,
    input  logic                  ssc_rd_i,
    input  logic                  ssp_rd_i,
    input  logic                  mb_rd_i,
    input  logic                  ssc_irq_n_i,
    input  logic                  ssp_irq_n_i,
    input  logic                  mb_irq_n_i,
    input  logic                  d_dir_i,
    input  logic                  irq_n_i,
    input  a2_glue_pkg::sample_t  audio_l_i,
    input  a2_glue_pkg::sample_t  audio_r_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;     // Assertion failures so far

    // Transceiver turns toward the Apple II only while a card answers
    dir_needs_read_a : assert property (
        @(posedge clk_logic_w) d_dir_i |-> (ssc_rd_i || ssp_rd_i || mb_rd_i)
    ) else begin
        $error("d_dir_o is high with no card read enable");
        fail_count++;
    end

    // Open-drain line is pulled low or released
    irq_never_high_a : assert property (
        @(posedge clk_logic_w) irq_n_i !== 1'b1
    ) else begin
        $error("irq_n_o is driven high");
        fail_count++;
    end

    irq_low_on_request_a : assert property (
        @(posedge clk_logic_w)
        !(ssc_irq_n_i && ssp_irq_n_i && mb_irq_n_i) |-> (irq_n_i === 1'b0)
    ) else begin
        $error("irq_n_o not pulled low during an interrupt request");
        fail_count++;
    end

    // Silent samples one cycle into reset
    audio_reset_a : assert property (
        @(posedge clk_logic_w)
        !system_reset_n_w |=> (audio_l_i == '0 && audio_r_i == '0)
    ) else begin
        $error("audio outputs not zero after a reset cycle");
        fail_count++;
    end

endmodule

`default_nettype wire

/* sim/a2_card_glue_tb.sv */
// Testbench for the card glue top level
// Seeded random stimulus on the falling edge, reference model,
// typed compare tasks and a cycle limit
`default_nettype none

`include "a2_glue_consts.svh"

module a2_card_glue_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import a2_glue_pkg::*;

    localparam int BLINK          = 64;
    localparam int SEED           = 32'h7cb14c90;
    localparam int AUDIO_CYCLES   = 500;
    localparam int ARB_CYCLES     = 500;
    localparam int HB_CYCLES      = 7 * BLINK;       // Alignment plus four wraps
    localparam int EDGE_CYCLES    = 6 * 1024;        // Q3 rises three times per phi1 period
    localparam int TIMEOUT_CYCLES = 3 + AUDIO_CYCLES + ARB_CYCLES + HB_CYCLES
                                  + EDGE_CYCLES + 200;

    logic         clk_logic_w;
    logic         system_reset_n_w;
    bus_byte_t    ssc_data, ssp_data, mb_data, a2_data, data_out;
    logic         ssc_rd, ssp_rd, mb_rd, ssc_irq_n, ssp_irq_n, mb_irq_n;
    logic         phi1, q3, speaker, d_dir, irq_n;
    card_audio_t  ssp_audio, mb_audio_l, mb_audio_r;
    sample_t      ext_l, ext_r, audio_l, audio_r;
    event_count_t es5503_count;
    logic         heartbeat_led, phi1_led, q3_led;
    int           cycle_count = 0;
    int           run_cycles  = 0;                   // Clock edges since reset release

    a2_card_glue_top #(.BLINK_CYCLES(BLINK), .ESP32_AUDIO_EN(1'b1)) uut (
        .clk_logic_w (clk_logic_w), .system_reset_n_w (system_reset_n_w),
        .ssc_data_i (ssc_data), .ssc_rd_i (ssc_rd), .ssc_irq_n_i (ssc_irq_n),
        .ssp_data_i (ssp_data), .ssp_rd_i (ssp_rd), .ssp_irq_n_i (ssp_irq_n),
        .mb_data_i (mb_data), .mb_rd_i (mb_rd), .mb_irq_n_i (mb_irq_n),
        .a2_data_i (a2_data), .phi1_i (phi1), .q3_i (q3),
        .data_out_o (data_out), .d_dir_o (d_dir), .irq_n_o (irq_n),
        .speaker_i (speaker), .ssp_audio_i (ssp_audio),
        .mb_audio_l_i (mb_audio_l), .mb_audio_r_i (mb_audio_r),
        .ext_l_i (ext_l), .ext_r_i (ext_r), .audio_l_o (audio_l), .audio_r_o (audio_r),
        .es5503_count_i (es5503_count), .heartbeat_led_o (heartbeat_led),
        .phi1_led_o (phi1_led), .q3_led_o (q3_led)
    );

    bind a2_card_glue_top a2_card_glue_asserts glue_checks (
        .clk_logic_w (clk_logic_w), .system_reset_n_w (system_reset_n_w),
        .ssc_rd_i (ssc_rd_i), .ssp_rd_i (ssp_rd_i), .mb_rd_i (mb_rd_i),
        .ssc_irq_n_i (ssc_irq_n_i), .ssp_irq_n_i (ssp_irq_n_i), .mb_irq_n_i (mb_irq_n_i),
        .d_dir_i (d_dir_o), .irq_n_i (irq_n_o),
        .audio_l_i (audio_l_o), .audio_r_i (audio_r_o)
    );

    always #4 clk_logic_w = ~clk_logic_w;

    always @(posedge clk_logic_w) begin
        run_cycles  <= system_reset_n_w ? run_cycles + 1 : 0;
        cycle_count <= cycle_count + 1;
        if (uut.glue_checks.fail_count != 0) begin
            stop_run("A bound assertion on the DUT failed");
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("Timeout: no result after %0d clock cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic check_byte(input string name, input bus_byte_t exp, input bus_byte_t act);
        if (act !== exp) begin
            stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp) begin
            stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Reference model
    function automatic bus_byte_t expected_bus(input logic [2:0] rd, input bus_byte_t bus);
        if (rd[0]) return ssc_data;                  // Serial card has priority
        if (rd[1]) return ssp_data;
        if (rd[2]) return mb_data;
        return bus;
    endfunction

    function automatic sample_t expected_mix(input logic spk, input card_audio_t ssp,
                                             input card_audio_t mb, input sample_t ext);
        int total;
        total = int'(spk) * (1 << `A2G_SPEAKER_SHIFT)
              + (int'(ssp) + int'(mb)) * (1 << `A2G_CARD_AUDIO_SHIFT) + int'(ext);
        return sample_t'(total);                     // Wraps modulo 2^16
    endfunction

    function automatic logic edge_led(input int edges);
        return logic'((edges >> `A2G_CLOCK_LED_BIT) & 1);
    endfunction

    task automatic drive_audio_random();
        speaker    = 1'($urandom);
        ssp_audio  = card_audio_t'($urandom);
        mb_audio_l = card_audio_t'($urandom);
        mb_audio_r = card_audio_t'($urandom);
        ext_l      = sample_t'($urandom);
        ext_r      = sample_t'($urandom);
    endtask

    task automatic audio_mix_test();
        logic        spk_prev;
        card_audio_t ssp_prev, l_prev, r_prev;
        sample_t     el_prev, er_prev;
        for (int n = 0; n < AUDIO_CYCLES; n++) begin
            spk_prev = speaker;
            ssp_prev = ssp_audio;
            l_prev   = mb_audio_l;
            r_prev   = mb_audio_r;
            el_prev  = ext_l;
            er_prev  = ext_r;
            @(negedge clk_logic_w);
            check_sample("audio mix left", expected_mix(spk_prev, ssp_prev, l_prev, el_prev),
                         audio_l);
            check_sample("audio mix right", expected_mix(spk_prev, ssp_prev, r_prev, er_prev),
                         audio_r);
            drive_audio_random();
        end
    endtask

    task automatic bus_arbitration_test();
        logic any_irq;
        for (int n = 0; n < ARB_CYCLES; n++) begin
            @(negedge clk_logic_w);
            {ssc_rd, ssp_rd, mb_rd}          = 3'($urandom);
            {ssc_irq_n, ssp_irq_n, mb_irq_n} = 3'($urandom);
            {ssc_data, ssp_data, mb_data}    = 24'($urandom);
            a2_data                          = bus_byte_t'($urandom);
            @(posedge clk_logic_w);
            any_irq = !(ssc_irq_n && ssp_irq_n && mb_irq_n);
            check_byte("bus data", expected_bus({mb_rd, ssp_rd, ssc_rd}, a2_data), data_out);
            check_bit("data direction",
                      (ssc_rd || ssp_rd || mb_rd) && (`A2G_DATA_OUT_ENABLE != 0), d_dir);
            check_bit("irq line", (any_irq && (`A2G_IRQ_OUT_ENABLE != 0)) ? 1'b0 : 1'bz,
                      irq_n);
        end
    endtask

    // Wrap of the blink counter lands just before phase 0
    task automatic step_to_phase(input int phase);
        do begin
            @(negedge clk_logic_w);
        end while (run_cycles % BLINK != phase);
    endtask

    task automatic heartbeat_test();
        logic         hb_exp;
        event_count_t new_count;
        step_to_phase(0);
        hb_exp = logic'((run_cycles / BLINK) % 2);   // Every wrap so far was idle
        check_bit("heartbeat after idle wraps", hb_exp, heartbeat_led);
        repeat (2) begin
            step_to_phase(BLINK - 1);
            check_bit("heartbeat before wrap", hb_exp, heartbeat_led);
            step_to_phase(0);
            hb_exp = ~hb_exp;
            check_bit("heartbeat toggle", hb_exp, heartbeat_led);
        end
        // Bit 8 picked so that a plain toggle would differ
        step_to_phase(BLINK / 3);
        new_count                    = event_count_t'($urandom);
        new_count[`A2G_ACTIVITY_BIT] = hb_exp;
        if (new_count == es5503_count) begin
            new_count[0] = ~new_count[0];
        end
        es5503_count = new_count;
        step_to_phase(0);
        hb_exp = new_count[`A2G_ACTIVITY_BIT];
        check_bit("heartbeat activity bit", hb_exp, heartbeat_led);
        step_to_phase(0);
        hb_exp = ~hb_exp;
        check_bit("heartbeat toggle after activity", hb_exp, heartbeat_led);
    endtask

    task automatic clock_presence_test();
        int   phi1_edges;
        int   q3_edges;
        logic phi1_next;
        logic q3_next;
        phi1_edges = 0;
        q3_edges   = 0;
        for (int k = 0; k < EDGE_CYCLES; k++) begin
            @(negedge clk_logic_w);
            phi1_next = (k % 6) < 3;
            q3_next   = (k % 2) == 0;
            if (phi1_next && !phi1) phi1_edges++;
            if (q3_next && !q3) q3_edges++;
            phi1 = phi1_next;
            q3   = q3_next;
        end
        repeat (3) @(negedge clk_logic_w);           // Four cycles after the last Q3 edge
        check_bit("phi1 clock led", edge_led(phi1_edges), phi1_led);
        check_bit("q3 clock led", edge_led(q3_edges), q3_led);
    endtask

    initial begin
        void'($urandom(SEED));
        clk_logic_w      = 1'b0;
        system_reset_n_w = 1'b0;
        {ssc_data, ssp_data, mb_data, a2_data} = '0;
        {ssc_rd, ssp_rd, mb_rd}                = '0;
        {ssc_irq_n, ssp_irq_n, mb_irq_n}       = '1;
        phi1         = 1'b0;
        q3           = 1'b0;
        es5503_count = event_count_t'($urandom);
        drive_audio_random();                        // Nonzero sources during reset
        repeat (3) @(negedge clk_logic_w);
        system_reset_n_w = 1'b1;
        check_sample("audio reset left", '0, audio_l);
        check_sample("audio reset right", '0, audio_r);
        audio_mix_test();
        bus_arbitration_test();
        heartbeat_test();
        clock_presence_test();
        if (uut.glue_checks.fail_count != 0) begin
            stop_run("A bound assertion on the DUT failed");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* a2_card_glue.f */
+incdir+hdl
hdl/a2_glue_pkg.sv
hdl/card_resp_if.sv
hdl/card_bus_arbiter.sv
hdl/audio_mixer.sv
hdl/status_led.sv
hdl/a2_card_glue_top.sv
sim/a2_card_glue_asserts.sv
sim/a2_card_glue_tb.sv
